// ==== design/owt_pkg.sv ====
/*
 * Shared widths, frame constants and types for the one-wire transmitter.
 * Frame layout is fixed: sync head, sync tail, command, optional data,
 * CRC-8 (poly 0x07, init 0, MSB first) and end tail.
 */
package owt_pkg;

    // ======================================================================
    // field widths
    // ======================================================================
    typedef logic [6:0] owt_addr_t;
    typedef logic [7:0] owt_data_t;
    // bit 7 is the write flag, bits 6:0 the address
    typedef logic [7:0] owt_cmd_t;
    typedef logic [7:0] owt_crc_t;

    // ======================================================================
    // frame constants
    // ======================================================================
    // manchester zeros in the sync head
    localparam int OWT_SYNC_BITS = 4;

    // raw slots, shared by sync tail and end tail
    localparam logic [3:0] OWT_TAIL_PATTERN = 4'b1100;
    localparam int OWT_TAIL_SLOTS = $bits(OWT_TAIL_PATTERN);

    // watchdog adc register
    localparam owt_addr_t OWT_ADC_ADDR = 7'h3A;

    localparam owt_crc_t OWT_CRC_POLY = 8'h07;

    localparam logic OWT_RD_FLAG = 1'b0;
    localparam logic OWT_WR_FLAG = 1'b1;

    // ======================================================================
    // sequencer state and bundles
    // ======================================================================
    typedef enum logic [2:0] {
        IDLE,
        SYNC_HEAD,
        SYNC_TAIL,
        CMD,
        DATA,
        CRC,
        END_TAIL
    } owt_seg_e;

    // latched frame contents, 17 bits
    typedef struct packed {
        owt_cmd_t  cmd;
        owt_data_t data;
        logic      has_data;
    } owt_frame_t;

    // one line symbol, a manchester bit or a single raw slot
    typedef struct packed {
        logic value;
        logic manchester;
    } owt_sym_t;

endpackage

// ==== design/owt_crc8_serial.sv ====
/*
 * Bit-serial CRC-8, MSB first, no reflection, zero initial value.
 * Clear wins over shift in the same cycle.
 */
`timescale 1ns/10ps

module owt_crc8_serial
    import owt_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_clear,
    input  logic     i_shift,
    input  logic     i_bit,
    output owt_crc_t o_crc
);

    logic feedback;

    assign feedback = i_bit ^ o_crc[7];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_crc <= '0;
        end else if (i_clear) begin
            o_crc <= '0;
        end else if (i_shift) begin
            o_crc <= {o_crc[6:0], 1'b0} ^ (feedback ? OWT_CRC_POLY : '0);
        end
    end

endmodule

// ==== design/owt_line_encoder.sv ====
/*
 * Holds each line slot for HALF_BIT_CYC cycles.
 * Manchester symbols take two slots (b then ~b), raw symbols one.
 * Line is low whenever no symbol is valid.
 */
`timescale 1ns/10ps

module owt_line_encoder
    import owt_pkg::*;
#(
    parameter int HALF_BIT_CYC = 12
) (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  owt_sym_t i_sym,
    input  logic     i_sym_valid,
    output logic     o_sym_done,
    output logic     o_owt_tx
);

    localparam int TW = (HALF_BIT_CYC > 1) ? $clog2(HALF_BIT_CYC) : 1;

    typedef logic [TW-1:0] slot_cnt_t;

    slot_cnt_t slot_cnt;
    logic      slot_end;
    // second manchester half
    logic      phase;

    assign slot_end   = (slot_cnt == slot_cnt_t'(HALF_BIT_CYC - 1));
    assign o_sym_done = i_sym_valid & slot_end & (phase | ~i_sym.manchester);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            slot_cnt <= '0;
            phase    <= 1'b0;
        end else if (!i_sym_valid) begin
            slot_cnt <= '0;
            phase    <= 1'b0;
        end else if (slot_end) begin
            slot_cnt <= '0;
            // next symbol starts on its first half
            phase    <= o_sym_done ? 1'b0 : 1'b1;
        end else begin
            slot_cnt <= slot_cnt + slot_cnt_t'(1);
        end
    end

    assign o_owt_tx = i_sym_valid & (i_sym.value ^ (phase & i_sym.manchester));

endmodule

// ==== design/owt_tx_arbiter.sv ====
/*
 * Grants one request at a time, host first; read wins over write.
 * i_addr and i_data are sampled on the grant only.
 * A new grant is possible in the last cycle of the running frame.
 */
`timescale 1ns/10ps

module owt_tx_arbiter
    import owt_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_wr_req,
    input  logic       i_rd_req,
    input  logic       i_adc_req,
    input  owt_addr_t  i_addr,
    input  owt_data_t  i_data,
    input  logic       i_frame_done,
    output logic       o_host_ack,
    output logic       o_adc_ack,
    output logic       o_start,
    output owt_frame_t o_frame
);

    logic busy;
    logic free;
    logic host_req;
    logic host_grant;
    logic adc_grant;
    logic rw_flag;

    assign host_req = i_wr_req | i_rd_req;
    assign rw_flag  = i_rd_req ? OWT_RD_FLAG : OWT_WR_FLAG;

    // the finishing frame frees the line for the next cycle
    assign free       = ~busy | i_frame_done;
    assign host_grant = free & host_req;
    assign adc_grant  = free & i_adc_req & ~host_req;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy       <= 1'b0;
            o_host_ack <= 1'b0;
            o_adc_ack  <= 1'b0;
            o_start    <= 1'b0;
        end else begin
            o_host_ack <= host_grant;
            o_adc_ack  <= adc_grant;
            o_start    <= host_grant | adc_grant;
            if (host_grant | adc_grant) begin
                busy <= 1'b1;
            end else if (i_frame_done) begin
                busy <= 1'b0;
            end
        end
    end

    // frame payload, held until the next grant
    always_ff @(posedge i_clk) begin
        if (host_grant) begin
            o_frame.cmd      <= {rw_flag, i_addr};
            o_frame.data     <= i_data;
            o_frame.has_data <= 1'b1;
        end else if (adc_grant) begin
            o_frame.cmd      <= {OWT_RD_FLAG, OWT_ADC_ADDR};
            o_frame.data     <= '0;
            o_frame.has_data <= 1'b0;
        end
    end

endmodule

// ==== design/owt_frame_seq.sv ====
/*
 * Steps through the frame segments and presents one symbol at a time.
 * Advances on i_sym_done; the next symbol follows in the same cycle.
 * DATA is skipped when the frame carries no data byte.
 */
`timescale 1ns/10ps

module owt_frame_seq
    import owt_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_start,
    input  owt_frame_t i_frame,
    input  logic       i_sym_done,
    output owt_sym_t   o_sym,
    output logic       o_sym_valid,
    output logic       o_frame_done,
    output owt_cmd_t   o_cmd_lock
);

    owt_seg_e   state;
    owt_seg_e   state_nxt;
    logic [2:0] bit_cnt;
    logic [2:0] last_idx;
    logic [2:0] msb_idx;
    logic [1:0] tail_idx;
    logic       seg_end;
    logic       crc_shift;
    owt_crc_t   crc_val;

    // ======================================================================
    // bit position within the segment
    // ======================================================================
    assign msb_idx  = 3'd7 - bit_cnt;
    assign tail_idx = 2'(OWT_TAIL_SLOTS - 1) - bit_cnt[1:0];

    always_comb begin
        case (state)
            SYNC_HEAD: last_idx = 3'(OWT_SYNC_BITS - 1);
            SYNC_TAIL,
            END_TAIL:  last_idx = 3'(OWT_TAIL_SLOTS - 1);
            default:   last_idx = 3'd7;
        endcase
    end

    assign seg_end = i_sym_done & (bit_cnt == last_idx);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bit_cnt <= '0;
        end else if ((state == IDLE) || seg_end) begin
            bit_cnt <= '0;
        end else if (i_sym_done) begin
            bit_cnt <= bit_cnt + 3'd1;
        end
    end

    // ======================================================================
    // segment FSM
    // ======================================================================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (i_start) begin
                    state_nxt = SYNC_HEAD;
                end
            end
            SYNC_HEAD: begin
                if (seg_end) begin
                    state_nxt = SYNC_TAIL;
                end
            end
            SYNC_TAIL: begin
                if (seg_end) begin
                    state_nxt = CMD;
                end
            end
            CMD: begin
                if (seg_end) begin
                    state_nxt = i_frame.has_data ? DATA : CRC;
                end
            end
            DATA: begin
                if (seg_end) begin
                    state_nxt = CRC;
                end
            end
            CRC: begin
                if (seg_end) begin
                    state_nxt = END_TAIL;
                end
            end
            END_TAIL: begin
                if (seg_end) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ======================================================================
    // symbol select
    // ======================================================================
    always_comb begin
        o_sym.value      = 1'b0;
        o_sym.manchester = 1'b1;
        o_sym_valid      = 1'b1;
        case (state)
            SYNC_HEAD: o_sym.value = 1'b0;
            CMD:       o_sym.value = i_frame.cmd[msb_idx];
            DATA:      o_sym.value = i_frame.data[msb_idx];
            CRC:       o_sym.value = crc_val[msb_idx];
            SYNC_TAIL,
            END_TAIL: begin
                o_sym.value      = OWT_TAIL_PATTERN[tail_idx];
                o_sym.manchester = 1'b0;
            end
            default: begin
                o_sym.manchester = 1'b0;
                o_sym_valid      = 1'b0;
            end
        endcase
    end

    // crc takes each command and data bit as its symbol completes
    assign crc_shift = i_sym_done & ((state == CMD) || (state == DATA));

    owt_crc8_serial u_crc8 (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_clear (i_start),
        .i_shift (crc_shift),
        .i_bit   (o_sym.value),
        .o_crc   (crc_val)
    );

    assign o_frame_done = seg_end & (state == END_TAIL);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_cmd_lock <= '0;
        end else if (o_frame_done) begin
            o_cmd_lock <= i_frame.cmd;
        end
    end

endmodule

// ==== design/owt_tx_top.sv ====
/*
 * One-wire bus transmitter, host and watchdog requesters.
 * Requests are levels held until their ack; host has priority.
 * HALF_BIT_CYC sets the clock cycles per line slot.
 */
`timescale 1ns/10ps

module owt_tx_top
    import owt_pkg::*;
#(
    parameter int HALF_BIT_CYC = 12
) (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_wr_req,
    input  logic      i_rd_req,
    input  logic      i_adc_req,
    input  owt_addr_t i_addr,
    input  owt_data_t i_data,
    output logic      o_host_ack,
    output logic      o_adc_ack,
    output logic      o_owt_tx,
    output owt_cmd_t  o_cmd_lock
);

    logic       start;
    owt_frame_t frame;
    logic       frame_done;
    owt_sym_t   sym;
    logic       sym_valid;
    logic       sym_done;

    owt_tx_arbiter u_arbiter (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_wr_req     (i_wr_req),
        .i_rd_req     (i_rd_req),
        .i_adc_req    (i_adc_req),
        .i_addr       (i_addr),
        .i_data       (i_data),
        .i_frame_done (frame_done),
        .o_host_ack   (o_host_ack),
        .o_adc_ack    (o_adc_ack),
        .o_start      (start),
        .o_frame      (frame)
    );

    owt_frame_seq u_frame_seq (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (start),
        .i_frame      (frame),
        .i_sym_done   (sym_done),
        .o_sym        (sym),
        .o_sym_valid  (sym_valid),
        .o_frame_done (frame_done),
        .o_cmd_lock   (o_cmd_lock)
    );

    owt_line_encoder #(
        .HALF_BIT_CYC (HALF_BIT_CYC)
    ) u_line_encoder (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_sym       (sym),
        .i_sym_valid (sym_valid),
        .o_sym_done  (sym_done),
        .o_owt_tx    (o_owt_tx)
    );

endmodule

// ==== tests/owt_tx_tb_clk.sv ====
/*
 * Testbench clock with a 10 ns period.
 * Active-low reset held for 4 cycles, released 1 ns after an edge.
 */
`timescale 1ns/10ps

module owt_tx_tb_clk (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (4) @(posedge o_clk);
        #1;
        o_rst_n = 1'b1;
    end

endmodule

// ==== tests/owt_tx_assert.sv ====
/*
 * Line, acknowledge and last-command checks on owt_tx_top.
 * The expected line, frame window and command come from the owt_tx_tb model.
 */
`timescale 1ns/10ps

module owt_tx_assert
    import owt_pkg::*;
(
    input logic     i_clk,
    input logic     i_rst_n,
    input logic     i_wr_req,
    input logic     i_rd_req,
    input logic     i_adc_req,
    input logic     i_host_ack,
    input logic     i_adc_ack,
    input logic     i_owt_tx,
    input owt_cmd_t i_cmd_lock,
    input logic     i_exp_tx,
    input logic     i_in_frame,
    input owt_cmd_t i_lock_exp
);

    int unsigned n_line = 0;
    int unsigned n_host = 0;
    int unsigned n_adc  = 0;
    int unsigned n_busy = 0;
    int unsigned n_lock = 0;
    int unsigned fail_cnt;

    assign fail_cnt = n_line + n_host + n_adc + n_busy + n_lock;

    // line slot by slot, and low outside frames
    a_line: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_owt_tx == i_exp_tx) else begin
        n_line = n_line + 1;
        $error("error o_owt_tx got %h expected %h", $sampled(i_owt_tx), $sampled(i_exp_tx));
    end

    a_host: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_host_ack |-> $past(i_wr_req || i_rd_req)) else begin
        n_host = n_host + 1;
        $error("o_host_ack rose with no host request pending");
    end

    // host has priority over the watchdog
    a_adc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_adc_ack |-> $past(i_adc_req) && !$past(i_wr_req || i_rd_req)) else begin
        n_adc = n_adc + 1;
        $error("o_adc_ack rose without a watchdog request or while the host was asking");
    end

    // also makes each ack a single-cycle pulse
    a_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_host_ack || i_adc_ack) |-> !i_in_frame) else begin
        n_busy = n_busy + 1;
        $error("acknowledge given while a frame was still on the line");
    end

    a_lock: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_cmd_lock == i_lock_exp) else begin
        n_lock = n_lock + 1;
        $error("error o_cmd_lock got %h expected %h", $sampled(i_cmd_lock),
            $sampled(i_lock_exp));
    end

endmodule

// ==== tests/owt_tx_tb.sv ====
/*
 * Testbench for owt_tx_top, HALF_BIT_CYC = 3.
 * Builds the expected slot sequence on each ack; bound assertions compare.
 */
`timescale 1ns/10ps

module owt_tx_tb
    import owt_pkg::*;
();

    localparam int HALF_BIT  = 3;
    localparam int N_FRAMES  = 7;
    localparam int CYC_LIMIT = N_FRAMES * 64 * HALF_BIT + 200;

    logic      clk;
    logic      rst_n;
    logic      wr_req;
    logic      rd_req;
    logic      adc_req;
    owt_addr_t addr;
    owt_data_t data;
    logic      host_ack;
    logic      adc_ack;
    logic      owt_tx;
    owt_cmd_t  cmd_lock;

    logic      exp_slots [64];
    int        n_slots;
    logic      in_frame;
    int        frame_cyc;
    owt_cmd_t  cur_cmd;
    owt_cmd_t  lock_exp;
    logic      exp_tx;

    integer      seed;
    int          cyc_cnt = 0;
    int unsigned errs_seen;
    int          n_tests;

    owt_tx_tb_clk u_clk (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    owt_tx_top #(
        .HALF_BIT_CYC (HALF_BIT)
    ) dut0 (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_wr_req   (wr_req),
        .i_rd_req   (rd_req),
        .i_adc_req  (adc_req),
        .i_addr     (addr),
        .i_data     (data),
        .o_host_ack (host_ack),
        .o_adc_ack  (adc_ack),
        .o_owt_tx   (owt_tx),
        .o_cmd_lock (cmd_lock)
    );

    bind owt_tx_top owt_tx_assert u_assert (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wr_req   (i_wr_req),
        .i_rd_req   (i_rd_req),
        .i_adc_req  (i_adc_req),
        .i_host_ack (o_host_ack),
        .i_adc_ack  (o_adc_ack),
        .i_owt_tx   (o_owt_tx),
        .i_cmd_lock (o_cmd_lock),
        .i_exp_tx   (owt_tx_tb.exp_tx),
        .i_in_frame (owt_tx_tb.in_frame),
        .i_lock_exp (owt_tx_tb.lock_exp)
    );

    // ======================================================================
    // expected slot model
    // ======================================================================
    task automatic add_slot(input logic b);
        exp_slots[6'(n_slots)] = b;
        n_slots = n_slots + 1;
    endtask

    // manchester bit, b then ~b
    task automatic add_bit(input logic b);
        add_slot(b);
        add_slot(~b);
    endtask

    task automatic add_tail();
        add_slot(1'b1);
        add_slot(1'b1);
        add_slot(1'b0);
        add_slot(1'b0);
    endtask

    // crc-8 as the remainder of msg * x^8 divided by x^8 + x^2 + x + 1
    function automatic owt_crc_t crc_divide(input logic [15:0] msg, input int n_bits);
        logic [23:0] rem;
        rem = {msg, 8'h00};
        for (int i = 0; i < n_bits; i++) begin
            if (rem[23 - i]) begin
                rem = rem ^ (24'h107 << (15 - i));
            end
        end
        crc_divide = rem[(23 - n_bits) -: 8];
    endfunction

    task automatic build_model(input logic host);
        logic [15:0] payload;
        int          n_bits;
        owt_crc_t    crc;
        if (host) begin
            cur_cmd = {~rd_req, addr};
            payload = {cur_cmd, data};
            n_bits  = 16;
        end else begin
            cur_cmd = {1'b0, 7'h3A};
            payload = {cur_cmd, 8'h00};
            n_bits  = 8;
        end
        n_slots = 0;
        crc     = crc_divide(payload, n_bits);
        for (int i = 0; i < 4; i++) begin
            add_bit(1'b0);
        end
        add_tail();
        for (int i = 0; i < n_bits; i++) begin
            add_bit(payload[4'(15 - i)]);
        end
        for (int i = 0; i < 8; i++) begin
            add_bit(crc[3'(7 - i)]);
        end
        add_tail();
    endtask

    // frame window starts the cycle after the ack
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_frame  <= 1'b0;
            frame_cyc <= 0;
            lock_exp  <= '0;
        end else if (host_ack || adc_ack) begin
            build_model(host_ack);
            in_frame  <= 1'b1;
            frame_cyc <= 0;
        end else if (in_frame) begin
            frame_cyc <= frame_cyc + 1;
            if (frame_cyc == n_slots * HALF_BIT - 1) begin
                in_frame <= 1'b0;
                lock_exp <= cur_cmd;
            end
        end
    end

    assign exp_tx = in_frame ? exp_slots[6'(frame_cyc / HALF_BIT)] : 1'b0;

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= CYC_LIMIT) begin
            $display("timeout, run exceeded %0d cycles", CYC_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    // ======================================================================
    // stimulus
    // ======================================================================
    task automatic wait_ack(input logic host);
        do begin
            @(posedge clk);
            #1;
        end while (host ? !host_ack : !adc_ack);
    endtask

    // one edge past the frame so the new o_cmd_lock is checked too
    task automatic wait_frame_end();
        do begin
            @(posedge clk);
            #1;
        end while (in_frame);
        @(posedge clk);
        #1;
    endtask

    // request dropped in the cycle after its ack
    task automatic host_request(input logic write);
        addr   = owt_addr_t'($random(seed));
        data   = owt_data_t'($random(seed));
        wr_req = write;
        rd_req = ~write;
        wait_ack(1'b1);
        @(posedge clk);
        #1;
        wr_req = 1'b0;
        rd_req = 1'b0;
    endtask

    task automatic adc_request();
        adc_req = 1'b1;
        wait_ack(1'b0);
        @(posedge clk);
        #1;
        adc_req = 1'b0;
    endtask

    task automatic report_test(input string name);
        int unsigned now;
        now = dut0.u_assert.fail_cnt;
        $display("test %0s: %0d errors", name, now - errs_seen);
        errs_seen = now;
        n_tests   = n_tests + 1;
    endtask

    initial begin
        seed      = 32'hfaf6;
        wr_req    = 1'b0;
        rd_req    = 1'b0;
        adc_req   = 1'b0;
        addr      = '0;
        data      = '0;
        errs_seen = 0;
        n_tests   = 0;
        @(posedge rst_n);
        repeat (5) @(posedge clk);
        #1;
        report_test("reset_idle");
        host_request(1'b1);
        wait_frame_end();
        report_test("host_write");
        host_request(1'b0);
        wait_frame_end();
        report_test("host_read");
        adc_request();
        wait_frame_end();
        report_test("adc_read");
        // both raised in the same cycle, host first
        adc_req = 1'b1;
        host_request(1'b1);
        adc_request();
        wait_frame_end();
        report_test("host_over_adc");
        // host request waits out a running watchdog frame
        adc_request();
        repeat (40) @(posedge clk);
        #1;
        host_request(1'b1);
        wait_frame_end();
        report_test("held_while_busy");
        $display("%0d tests, %0d errors", n_tests, dut0.u_assert.fail_cnt);
        if (dut0.u_assert.fail_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
design/owt_pkg.sv
design/owt_crc8_serial.sv
design/owt_line_encoder.sv
design/owt_tx_arbiter.sv
design/owt_frame_seq.sv
design/owt_tx_top.sv
tests/owt_tx_tb_clk.sv
tests/owt_tx_assert.sv
tests/owt_tx_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the owt transmitter testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module owt_tx_tb -f filelist.f -o owt_tx_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/owt_tx_sim +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q '^Done: no errors$'; then
    exit 0
fi
exit 1
